// ==== wb_mem_pkg.sv ====
// ============================================================
// Shared types for the Wishbone SRAM subsystem
// ============================================================
package wb_mem_pkg;

    // Bus data width in bits, and the number of byte lanes in it.
    localparam int BUS_DW    = 32;
    localparam int BUS_BYTES = BUS_DW / 8;

    // One bus word. Used for write data, read data and the RAM contents.
    typedef logic [BUS_DW-1:0] word_t;

    // Byte-lane select. Bit n covers data bits 8n+7 down to 8n.
    typedef logic [BUS_BYTES-1:0] sel_t;

    // Byte address as it appears on the bus.
    typedef logic [31:0] bus_adr_t;

    // States of the host command bridge.
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // Waiting for a host request.
        BUS  = 2'd1,    // Wishbone cycle open, waiting for ack.
        DONE = 2'd2     // One-cycle done pulse to the host.
    } bridge_state_e;

endpackage : wb_mem_pkg

// ==== wb_if.sv ====
`timescale 1ns/10ps

// Classic Wishbone bus for one master and one slave.
// Only single transfers are carried, so there are no burst or error lines.
interface wb_if
    import wb_mem_pkg::*;
();

    logic     cyc;      // Bus cycle in progress.
    logic     stb;      // Transfer strobe.
    logic     we;       // High for a write, low for a read.
    sel_t     sel;      // Byte lanes taking part in the transfer.
    bus_adr_t adr;      // Byte address.
    word_t    dat_w;    // Master to slave data.
    word_t    dat_r;    // Slave to master data.
    logic     ack;      // Transfer acknowledge, one cycle wide.

    // The bridge side.
    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    // The memory side.
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface : wb_if

// ==== wb_cmd_bridge.sv ====
`timescale 1ns/10ps

// Turns a single host request strobe into one classic Wishbone cycle.
// The host sees busy_o while a transfer is in flight and a done_o pulse
// at its end; read data is returned on rdata_o and held until the next read.
module wb_cmd_bridge
    import wb_mem_pkg::*;
#(
    parameter int ADR_WIDTH = 8
) (
    input  logic     wb_clk_i,
    input  logic     arst_n_i,

    // Host command port.
    input  logic     req_i,
    input  logic     we_i,
    input  bus_adr_t adr_i,
    input  sel_t     sel_i,
    input  word_t    dat_i,
    output logic     busy_o,
    output logic     done_o,
    output word_t    rdata_o,

    // Wishbone master side.
    wb_if.master     bus
);

    bridge_state_e state_q;
    bridge_state_e state_d;

    logic     cyc_q;        // Drives both cyc and stb.
    logic     we_q;
    sel_t     sel_q;
    bus_adr_t adr_q;
    word_t    dat_q;
    word_t    rdata_q;

    logic     take_req;     // A request is accepted on this edge.
    logic     bus_end;      // The slave acknowledges on this edge.

    assign take_req = (state_q == IDLE) && req_i; // Requests while busy are dropped.
    assign bus_end  = (state_q == BUS) && bus.ack;

    // ============================================================
    // Control FSM
    // ============================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = BUS;
                end
            end
            BUS: begin
                if (bus.ack) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;     // The port frees one cycle after done.
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cyc_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_req) begin
                cyc_q <= 1'b1;
            end else if (bus_end) begin
                cyc_q <= 1'b0;      // Cycle closes on the same edge that sees ack.
            end
        end
    end

    // ============================================================
    // Request and response payload
    // ============================================================

    // The bus fields are loaded once per request and stay put until ack.
    // The address goes out word aligned and limited to the memory window.
    always_ff @(posedge wb_clk_i) begin
        if (take_req) begin
            we_q  <= we_i;
            sel_q <= sel_i;
            adr_q <= bus_adr_t'({adr_i[ADR_WIDTH+1:2], 2'b00});
            dat_q <= dat_i;
        end
    end

    // Read data is taken from the bus in the ack cycle.
    always_ff @(posedge wb_clk_i) begin
        if (bus_end && !we_q) begin
            rdata_q <= bus.dat_r;
        end
    end

    // Wishbone master outputs.
    assign bus.cyc   = cyc_q;
    assign bus.stb   = cyc_q;
    assign bus.we    = we_q;
    assign bus.sel   = sel_q;
    assign bus.adr   = adr_q;
    assign bus.dat_w = dat_q;

    // Host status, decoded from the state register.
    assign busy_o  = (state_q != IDLE);
    assign done_o  = (state_q == DONE);
    assign rdata_o = rdata_q;

endmodule : wb_cmd_bridge

// ==== mem_wb.sv ====
`timescale 1ns/10ps

// Wishbone slave in front of the on-chip RAM.
// It decodes the cycle, forms the byte write enables and times the ack.
module mem_wb
    import wb_mem_pkg::*;
#(
    parameter int ADR_WIDTH = 8
) (
    input  logic                 wb_clk_i,
    input  logic                 arst_n_i,

    // Wishbone slave side.
    wb_if.slave                  bus,

    // RAM port.
    output logic                 ram_ena_o,
    output sel_t                 ram_wen_o,
    output logic [ADR_WIDTH-1:0] ram_addr_o,
    output word_t                ram_wdata_o,
    input  word_t                ram_rdata_i
);

    logic valid;        // A transfer is on the bus.
    logic wr_valid;     // It is a write.
    logic ack_q;
    logic rd_pend_q;    // Read accepted, RAM data is being registered.

    assign valid    = bus.cyc & bus.stb;
    assign wr_valid = valid & bus.we;

    // ============================================================
    // RAM side decode
    // ============================================================

    assign ram_ena_o   = valid;
    assign ram_wen_o   = bus.sel & {$bits(sel_t){wr_valid}}; // Lanes only on writes.
    assign ram_addr_o  = bus.adr[ADR_WIDTH+1:2];              // Word address.
    assign ram_wdata_o = bus.dat_w;

    // ============================================================
    // Acknowledge generation
    // ============================================================

    // A write is acknowledged one cycle after the strobe is seen.
    // A read waits one more cycle through the read flag, so that the
    // registered RAM output is stable when ack is high.
    // The ack and flag terms stop a held strobe from starting a second transfer.
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q     <= 1'b0;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= valid & ~bus.we & ~ack_q & ~rd_pend_q;
            if (bus.we) begin
                ack_q <= valid & ~ack_q;
            end else begin
                ack_q <= rd_pend_q;
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = ram_rdata_i;   // RAM output is already registered.

endmodule : mem_wb

// ==== soc_ram.sv ====
`timescale 1ns/10ps

// Single-port synchronous RAM with byte-lane writes.
// Stands in for the hard RAM macro, and like the macro it has no reset.
module soc_ram
    import wb_mem_pkg::*;
#(
    parameter int MEM_WORDS = 256,
    parameter int ADR_WIDTH = 8
) (
    input  logic                 wb_clk_i,
    input  logic                 ena_i,
    input  sel_t                 wen_i,
    input  logic [ADR_WIDTH-1:0] addr_i,
    input  word_t                wdata_i,
    output word_t                rdata_o
);

    localparam int LANES = $bits(sel_t);

    word_t mem [MEM_WORDS];

    // ============================================================
    // Write port
    // ============================================================

    // Each enabled lane updates its own byte. Other bytes keep their value.
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            for (int b = 0; b < LANES; b++) begin
                if (wen_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ============================================================
    // Read port
    // ============================================================

    // The output register loads on every enabled edge.
    // During a write it returns the word as it was before the write.
    always_ff @(posedge wb_clk_i) begin
        if (ena_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule : soc_ram

// ==== wb_mem_sub.sv ====
`timescale 1ns/10ps

// On-chip SRAM subsystem.
// Host command port -> bridge -> Wishbone -> memory slave -> RAM.
module wb_mem_sub
    import wb_mem_pkg::*;
#(
    parameter int MEM_WORDS = 256     // Must be a power of two.
) (
    input  logic     wb_clk_i,
    input  logic     arst_n_i,

    // Host command port.
    input  logic     req_i,
    input  logic     we_i,
    input  bus_adr_t adr_i,
    input  sel_t     sel_i,
    input  word_t    dat_i,
    output logic     busy_o,
    output logic     done_o,
    output word_t    rdata_o
);

    localparam int ADR_WIDTH = $clog2(MEM_WORDS);

    // RAM port wiring.
    logic                 ram_ena;
    sel_t                 ram_wen;
    logic [ADR_WIDTH-1:0] ram_addr;
    word_t                ram_wdata;
    word_t                ram_rdata;

    wb_if wb_bus ();

    wb_cmd_bridge #(
        .ADR_WIDTH (ADR_WIDTH)
    ) u_bridge (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .adr_i    (adr_i),
        .sel_i    (sel_i),
        .dat_i    (dat_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .rdata_o  (rdata_o),
        .bus      (wb_bus.master)
    );

    mem_wb #(
        .ADR_WIDTH (ADR_WIDTH)
    ) u_mem_wb (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .bus         (wb_bus.slave),
        .ram_ena_o   (ram_ena),
        .ram_wen_o   (ram_wen),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    soc_ram #(
        .MEM_WORDS (MEM_WORDS),
        .ADR_WIDTH (ADR_WIDTH)
    ) u_ram (
        .wb_clk_i (wb_clk_i),
        .ena_i    (ram_ena),
        .wen_i    (ram_wen),
        .addr_i   (ram_addr),
        .wdata_i  (ram_wdata),
        .rdata_o  (ram_rdata)
    );

endmodule : wb_mem_sub

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

// Free-running clock and power-on reset for the testbench.
module tb_clk_gen #(
    parameter int CLK_PERIOD_NS = 20,
    parameter int RST_CYCLES    = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset is released on a falling edge, away from the active edge.
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

// ==== tb_wb_mem_sub.sv ====
`timescale 1ns/10ps

// Directed tests for the Wishbone SRAM subsystem.
// A reference memory follows every write, and reads are compared against it.
module tb_wb_mem_sub
    import wb_mem_pkg::*;
();

    localparam int MEM_WORDS      = 256;
    localparam int ADR_W          = $clog2(MEM_WORDS);
    localparam int CLK_PERIOD_NS  = 20;
    localparam int RST_CYCLES     = 8;
    localparam int WR_LATENCY     = 2;     // Sampling edge to done, in cycles.
    localparam int RD_LATENCY     = 3;
    localparam int XFER_LIMIT     = 20;    // Cycles allowed for one transfer.
    localparam int SWEEP_XFERS    = 200;
    localparam int DIRECTED_XFERS = 41;    // Transfers in the directed tests.
    localparam int WATCHDOG_CYCLES =
        (DIRECTED_XFERS + SWEEP_XFERS) * 10 + RST_CYCLES + 100;

    logic     wb_clk;
    logic     arst_n;
    logic     host_req;
    logic     host_we;
    bus_adr_t host_adr;
    sel_t     host_sel;
    word_t    host_dat;
    logic     busy;
    logic     done;
    word_t    rdata;

    word_t    ref_mem [MEM_WORDS];     // Expected contents, by word address.
    bit       written [MEM_WORDS];
    bus_adr_t wr_list [$];             // Every address written so far.
    bit       poke_en;                 // Pulse a second request mid-transfer.
    bus_adr_t poke_adr;
    int       seed = 54162;
    int       check_cnt;
    int       err_cnt;
    string    test_name;

    tb_clk_gen #(
        .CLK_PERIOD_NS (CLK_PERIOD_NS),
        .RST_CYCLES    (RST_CYCLES)
    ) u_clk_gen (
        .clk_o   (wb_clk),
        .rst_n_o (arst_n)
    );

    wb_mem_sub #(
        .MEM_WORDS (MEM_WORDS)
    ) dut0 (
        .wb_clk_i (wb_clk),
        .arst_n_i (arst_n),
        .req_i    (host_req),
        .we_i     (host_we),
        .adr_i    (host_adr),
        .sel_i    (host_sel),
        .dat_i    (host_dat),
        .busy_o   (busy),
        .done_o   (done),
        .rdata_o  (rdata)
    );

    // ============================================================
    // Reference model and checks
    // ============================================================

    // Only bits ADR_W+1 down to 2 pick the word.
    function automatic int word_index(bus_adr_t adr);
        return int'(adr[ADR_W+1:2]);
    endfunction

    // Selected bytes take the new value, the others keep the old one.
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        check_cnt++;
        assert (act == exp) else begin
            $display("error: %s: %s expected %h actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_num(input string what, input int exp, input int act);
        check_cnt++;
        assert (act == exp) else begin
            $display("error: %s: %s expected %0d actual %0d", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    // ============================================================
    // Host port transfers
    // ============================================================

    // Starts on a falling edge with the port free, ends one edge after done.
    task automatic run_transfer(input logic we, input bus_adr_t adr, input sel_t sel,
                                input word_t dat, output word_t rd);
        int            lat;
        int            exp_lat;
        bridge_state_e st;
        lat      = 0;
        exp_lat  = we ? WR_LATENCY : RD_LATENCY;
        rd       = '0;
        host_req = 1'b1;
        host_we  = we;
        host_adr = adr;
        host_sel = sel;
        host_dat = dat;
        @(negedge wb_clk);                      // Edge 0 has sampled the request.
        while (!done && lat < XFER_LIMIT) begin
            check_num("busy while in flight", 1, int'(busy));
            if (poke_en && lat == 1) begin
                host_req = 1'b1;                // This one must be dropped.
                host_we  = 1'b1;
                host_adr = poke_adr;
                host_sel = 4'hF;
                host_dat = ~dat;
            end else begin
                host_req = 1'b0;
            end
            @(negedge wb_clk);
            lat++;
        end
        host_req = 1'b0;
        st = dut0.u_bridge.state_q;
        check_cnt++;
        assert (done) else begin
            $display("timeout in %s: no done pulse within %0d cycles for address %h, bridge in %s",
                     test_name, XFER_LIMIT, adr, st.name());
            err_cnt++;
        end
        if (done) begin
            check_num("done latency", exp_lat, lat);
            check_num("busy in done cycle", 1, int'(busy));
            rd = rdata;                         // Valid while done is high.
            @(negedge wb_clk);
            check_num("busy after done", 0, int'(busy));
            check_num("done pulse width", 0, int'(done));
        end
    endtask

    task automatic write_word(input bus_adr_t adr, input sel_t sel, input word_t dat);
        word_t unused_rd;
        int    idx;
        run_transfer(1'b1, adr, sel, dat, unused_rd);
        idx          = word_index(adr);
        ref_mem[idx] = merge_bytes(ref_mem[idx], dat, sel);
        written[idx] = 1'b1;
        wr_list.push_back(adr);
    endtask

    task automatic read_check(input bus_adr_t adr);
        word_t rd;
        int    idx;
        run_transfer(1'b0, adr, 4'hF, '0, rd);
        idx = word_index(adr);
        check_word($sformatf("read of %h", adr), ref_mem[idx], rd);
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic test_reset_idle();
        bus_adr_t adrs [4];
        adrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0154, 32'h0000_03FC};
        test_name = "reset_idle";
        check_num("busy after reset", 0, int'(busy));
        check_num("done after reset", 0, int'(done));
        foreach (adrs[i]) begin
            write_word(adrs[i], 4'hF, 32'hA5C3_0000 ^ (adrs[i] * 32'h0101_0101));
        end
        foreach (adrs[i]) begin
            read_check(adrs[i]);
        end
    endtask

    task automatic test_byte_lanes();
        sel_t     sels [9];
        bus_adr_t adr;
        sels = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h6, 4'h9, 4'h0};
        adr  = 32'h0000_0040;
        test_name = "byte_lanes";
        write_word(adr, 4'hF, 32'h1122_3344);
        read_check(adr);
        foreach (sels[i]) begin
            write_word(adr, sels[i], 32'hF0E1_D2C3 ^ {8{sels[i]}});
            read_check(adr);
        end
    endtask

    task automatic test_addr_decode();
        bus_adr_t base;
        bus_adr_t high_bits;
        base      = 32'h0000_0120;
        high_bits = ~((32'h1 << (ADR_W + 2)) - 32'h1);   // Everything above the window.
        test_name = "addr_decode";
        write_word(base | 32'h3, 4'hF, 32'h5EED_0120);
        read_check(base);
        read_check(base | 32'h1);
        read_check(base | 32'h2);
        read_check(base | (32'h1 << (ADR_W + 2)));
        read_check(base | high_bits);
        write_word(high_bits | base | 32'h4, 4'hF, 32'h0BAD_F00D);
        read_check(base | 32'h4);
    endtask

    task automatic test_latency_busy();
        bus_adr_t adr_a;
        bus_adr_t adr_b;
        adr_a = 32'h0000_0200;
        adr_b = 32'h0000_0204;
        test_name = "latency_busy";
        write_word(adr_b, 4'hF, 32'hB0B0_0204);
        poke_adr = adr_b;
        poke_en  = 1'b1;
        write_word(adr_a, 4'hF, 32'hA0A0_0200);
        read_check(adr_a);
        poke_en  = 1'b0;
        read_check(adr_b);      // Still holds its own value.
        read_check(adr_a);
    endtask

    task automatic test_random_sweep();
        bus_adr_t adr;
        sel_t     sel;
        int       idx;
        int       pick;
        bit       do_wr;
        test_name = "random_sweep";
        for (int n = 0; n < SWEEP_XFERS; n++) begin
            do_wr = (wr_list.size() == 0) || ($random(seed) % 2 != 0);
            if (do_wr) begin
                adr = $random(seed);
                idx = word_index(adr);
                // A word seen for the first time is written whole.
                sel = written[idx] ? sel_t'($random(seed)) : 4'hF;
                write_word(adr, sel, $random(seed));
            end else begin
                pick = int'({$random(seed)} % wr_list.size());
                read_check(wr_list[pick]);
            end
        end
    endtask

    // ============================================================
    // Main sequence and watchdog
    // ============================================================

    initial begin : main_seq
        host_req  = 1'b0;
        host_we   = 1'b0;
        host_adr  = '0;
        host_sel  = '0;
        host_dat  = '0;
        poke_en   = 1'b0;
        poke_adr  = '0;
        check_cnt = 0;
        err_cnt   = 0;
        @(posedge arst_n);
        @(negedge wb_clk);
        test_reset_idle();
        test_byte_lanes();
        test_addr_decode();
        test_latency_busy();
        test_random_sweep();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_wb_mem_sub

// ==== wb_mem_sub.f ====
wb_mem_pkg.sv
wb_if.sv
wb_cmd_bridge.sv
mem_wb.sv
soc_ram.sv
wb_mem_sub.sv
tb_clk_gen.sv
tb_wb_mem_sub.sv

// ==== Makefile ====
SRCS := $(shell cat wb_mem_sub.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_wb_mem_sub: $(SRCS) wb_mem_sub.f
	verilator --binary --assert --timing --timescale 1ns/10ps -j 0 \
		--top-module tb_wb_mem_sub -f wb_mem_sub.f

run: obj_dir/Vtb_wb_mem_sub
	@out="$$(./obj_dir/Vtb_wb_mem_sub)"; echo "$$out"; \
	echo "$$out" | grep -qxF '*** PASSED ***'

clean:
	rm -rf obj_dir
